//--- verilog/lc3b_types.sv
`default_nettype none

package lc3b_types;

	typedef logic [15:0] lc3b_word;

	// Architectural register number, eight registers.
	typedef logic [2:0] lc3b_reg;

	typedef enum logic [2:0] {
		alu_add = 3'b000,
		alu_and = 3'b001,
		alu_not = 3'b010,
		alu_sll = 3'b011,
		alu_srl = 3'b100,
		alu_sra = 3'b101
	} alu_op_t;

	localparam int SHAMT_W = 4; // Low bits of b used as shift amount.

endpackage : lc3b_types

`default_nettype wire

//--- verilog/rs_types.sv
`default_nettype none

package rs_types;

	// Names the producer of a result on the CDB.
	typedef logic [2:0] rs_tag_t;

	localparam rs_tag_t TAG_NONE = 3'd0; // Operand already holds a value.

	localparam rs_tag_t RS0_TAG = 3'd1;
	localparam rs_tag_t RS1_TAG = 3'd2;

	// Tags 3 to 7 belong to producers outside this unit.

endpackage : rs_types

`default_nettype wire

//--- verilog/lc3b_alu.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_alu import lc3b_types::*; (
	input  wire alu_op_t  op,
	input  wire lc3b_word a,
	input  wire lc3b_word b,
	output lc3b_word      f
);

	logic [SHAMT_W-1:0] shamt;

	assign shamt = b[SHAMT_W-1:0];

	always_comb begin
		unique case (op)
			alu_add: begin
				f = a + b;
			end
			alu_and: begin
				f = a & b;
			end
			alu_not: begin
				f = ~a;
			end
			alu_sll: begin
				f = a << shamt;
			end
			alu_srl: begin
				f = a >> shamt;
			end
			alu_sra: begin
				f = lc3b_word'($signed(a) >>> shamt); // Sign bit repeats.
			end
			default: begin
				f = a;
			end
		endcase
	end

endmodule : lc3b_alu

`default_nettype wire

//--- verilog/alu_res_station.sv
`timescale 1ns/1ps
`default_nettype none

module alu_res_station import lc3b_types::*, rs_types::*; #(
	parameter rs_tag_t RS_TAG = RS0_TAG
) (
	input  wire logic     clk,
	input  wire logic     arst_n,
	input  wire logic     flush,
	input  wire logic     load,
	input  wire alu_op_t  issue_op,
	input  wire lc3b_word issue_vj,
	input  wire rs_tag_t  issue_qj,
	input  wire lc3b_word issue_vk,
	input  wire rs_tag_t  issue_qk,
	input  wire lc3b_reg  issue_dest,
	input  wire logic     cdb_valid,
	input  wire rs_tag_t  cdb_tag,
	input  wire lc3b_word cdb_data,
	input  wire logic     grant,
	output logic          busy,
	output logic          req,
	output lc3b_word      res_data,
	output lc3b_reg       res_dest
);

	alu_op_t  op_q;
	lc3b_word vj_q;
	lc3b_word vk_q;
	rs_tag_t  qj_q;
	rs_tag_t  qk_q;
	logic     busy_q;
	logic     exec_q;
	logic     req_q;
	lc3b_word alu_f;
	logic     wake_j;
	logic     wake_k;
	logic     fwd_j;
	logic     fwd_k;
	logic     ops_ready;

	// Snoop while waiting; this station never produces for itself.
	assign wake_j = busy_q && cdb_valid && qj_q != TAG_NONE && qj_q != RS_TAG &&
		cdb_tag == qj_q;
	assign wake_k = busy_q && cdb_valid && qk_q != TAG_NONE && qk_q != RS_TAG &&
		cdb_tag == qk_q;

	// Same-cycle broadcast at issue.
	assign fwd_j = cdb_valid && issue_qj != TAG_NONE && cdb_tag == issue_qj;
	assign fwd_k = cdb_valid && issue_qk != TAG_NONE && cdb_tag == issue_qk;

	assign ops_ready = busy_q && !exec_q && qj_q == TAG_NONE && qk_q == TAG_NONE;

	lc3b_alu alu0 (
		.op (op_q),
		.a  (vj_q),
		.b  (vk_q),
		.f  (alu_f)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy_q <= 1'b0;
			exec_q <= 1'b0;
			req_q  <= 1'b0;
			qj_q   <= TAG_NONE;
			qk_q   <= TAG_NONE;
		end else if (flush) begin
			busy_q <= 1'b0;
			exec_q <= 1'b0;
			req_q  <= 1'b0;
		end else if (load) begin
			busy_q <= 1'b1;
			exec_q <= 1'b0;
			req_q  <= 1'b0;
			qj_q   <= fwd_j ? TAG_NONE : issue_qj;
			qk_q   <= fwd_k ? TAG_NONE : issue_qk;
		end else if (grant) begin
			busy_q <= 1'b0; // Free on the grant edge.
			exec_q <= 1'b0;
			req_q  <= 1'b0;
		end else begin
			if (wake_j) begin
				qj_q <= TAG_NONE;
			end
			if (wake_k) begin
				qk_q <= TAG_NONE;
			end
			if (ops_ready) begin
				exec_q <= 1'b1;
			end
			if (exec_q) begin
				req_q <= 1'b1; // Result registered one cycle earlier.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			op_q     <= issue_op;
			res_dest <= issue_dest;
			vj_q     <= fwd_j ? cdb_data : issue_vj;
			vk_q     <= fwd_k ? cdb_data : issue_vk;
		end else begin
			if (wake_j) begin
				vj_q <= cdb_data;
			end
			if (wake_k) begin
				vk_q <= cdb_data;
			end
		end
		if (ops_ready) begin
			res_data <= alu_f; // Held until grant.
		end
	end

	assign busy = busy_q;
	assign req  = req_q && !flush; // No grant for an entry being flushed.

endmodule : alu_res_station

`default_nettype wire

//--- verilog/rs_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module rs_scheduler import lc3b_types::*, rs_types::*; (
	input  wire logic     clk,
	input  wire logic     arst_n,
	input  wire logic     issue_valid,
	input  wire logic     busy0,
	input  wire logic     busy1,
	input  wire logic     req0,
	input  wire logic     req1,
	input  wire lc3b_word res_data0,
	input  wire lc3b_word res_data1,
	input  wire lc3b_reg  res_dest0,
	input  wire lc3b_reg  res_dest1,
	input  wire logic     ext_wb_valid,
	input  wire rs_tag_t  ext_wb_tag,
	input  wire lc3b_word ext_wb_data,
	input  wire lc3b_reg  ext_wb_dest,
	output logic          issue_ready,
	output logic          load0,
	output logic          load1,
	output logic          grant0,
	output logic          grant1,
	output logic          cdb_valid,
	output rs_tag_t       cdb_tag,
	output lc3b_word      cdb_data,
	output lc3b_reg       cdb_dest
);

	logic rr_q; // Station preferred on a tie.

	always_comb begin
		issue_ready = !busy0 || !busy1;
		load0       = issue_valid && !busy0;
		load1       = issue_valid && busy0 && !busy1; // Station 0 first.
	end

	// Outside writeback owns the bus whenever it is valid.
	always_comb begin
		grant0 = 1'b0;
		grant1 = 1'b0;
		if (!ext_wb_valid) begin
			if (req0 && (!req1 || !rr_q)) begin
				grant0 = 1'b1;
			end else if (req1) begin
				grant1 = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rr_q      <= 1'b0;
			cdb_valid <= 1'b0;
		end else begin
			cdb_valid <= ext_wb_valid || grant0 || grant1;
			if (grant0) begin
				rr_q <= 1'b1;
			end else if (grant1) begin
				rr_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ext_wb_valid) begin
			cdb_tag  <= ext_wb_tag;
			cdb_data <= ext_wb_data;
			cdb_dest <= ext_wb_dest;
		end else if (grant0) begin
			cdb_tag  <= RS0_TAG;
			cdb_data <= res_data0;
			cdb_dest <= res_dest0;
		end else if (grant1) begin
			cdb_tag  <= RS1_TAG;
			cdb_data <= res_data1;
			cdb_dest <= res_dest1;
		end
	end

endmodule : rs_scheduler

`default_nettype wire

//--- verilog/alu_exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_exec_unit import lc3b_types::*, rs_types::*; (
	input  wire logic     clk,
	input  wire logic     arst_n,
	input  wire logic     flush,
	input  wire logic     issue_valid,
	input  wire alu_op_t  issue_op,
	input  wire lc3b_word issue_vj,
	input  wire rs_tag_t  issue_qj,
	input  wire lc3b_word issue_vk,
	input  wire rs_tag_t  issue_qk,
	input  wire lc3b_reg  issue_dest,
	output logic          issue_ready,
	input  wire logic     ext_wb_valid,
	input  wire rs_tag_t  ext_wb_tag,
	input  wire lc3b_word ext_wb_data,
	input  wire lc3b_reg  ext_wb_dest,
	output logic          cdb_valid,
	output rs_tag_t       cdb_tag,
	output lc3b_word      cdb_data,
	output lc3b_reg       cdb_dest
);

	logic     busy0;
	logic     busy1;
	logic     req0;
	logic     req1;
	logic     load0;
	logic     load1;
	logic     grant0;
	logic     grant1;
	lc3b_word res_data0;
	lc3b_word res_data1;
	lc3b_reg  res_dest0;
	lc3b_reg  res_dest1;

	alu_res_station #(.RS_TAG(RS0_TAG)) rs0 (
		.clk        (clk),
		.arst_n     (arst_n),
		.flush      (flush),
		.load       (load0),
		.issue_op   (issue_op),
		.issue_vj   (issue_vj),
		.issue_qj   (issue_qj),
		.issue_vk   (issue_vk),
		.issue_qk   (issue_qk),
		.issue_dest (issue_dest),
		.cdb_valid  (cdb_valid),
		.cdb_tag    (cdb_tag),
		.cdb_data   (cdb_data),
		.grant      (grant0),
		.busy       (busy0),
		.req        (req0),
		.res_data   (res_data0),
		.res_dest   (res_dest0)
	);

	alu_res_station #(.RS_TAG(RS1_TAG)) rs1 (
		.clk        (clk),
		.arst_n     (arst_n),
		.flush      (flush),
		.load       (load1),
		.issue_op   (issue_op),
		.issue_vj   (issue_vj),
		.issue_qj   (issue_qj),
		.issue_vk   (issue_vk),
		.issue_qk   (issue_qk),
		.issue_dest (issue_dest),
		.cdb_valid  (cdb_valid),
		.cdb_tag    (cdb_tag),
		.cdb_data   (cdb_data),
		.grant      (grant1),
		.busy       (busy1),
		.req        (req1),
		.res_data   (res_data1),
		.res_dest   (res_dest1)
	);

	rs_scheduler sched (
		.clk          (clk),
		.arst_n       (arst_n),
		.issue_valid  (issue_valid),
		.busy0        (busy0),
		.busy1        (busy1),
		.req0         (req0),
		.req1         (req1),
		.res_data0    (res_data0),
		.res_data1    (res_data1),
		.res_dest0    (res_dest0),
		.res_dest1    (res_dest1),
		.ext_wb_valid (ext_wb_valid),
		.ext_wb_tag   (ext_wb_tag),
		.ext_wb_data  (ext_wb_data),
		.ext_wb_dest  (ext_wb_dest),
		.issue_ready  (issue_ready),
		.load0        (load0),
		.load1        (load1),
		.grant0       (grant0),
		.grant1       (grant1),
		.cdb_valid    (cdb_valid),
		.cdb_tag      (cdb_tag),
		.cdb_data     (cdb_data),
		.cdb_dest     (cdb_dest)
	);

endmodule : alu_exec_unit

`default_nettype wire

//--- test/alu_exec_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module alu_exec_unit_tb import lc3b_types::*, rs_types::*; ();

	localparam int RESET_CYCLES = 16;
	localparam int NUM_OPS = 21;
	localparam int CYCLE_LIMIT = RESET_CYCLES + 40 * NUM_OPS;

	logic     clk;
	logic     arst_n;
	logic     flush;
	logic     issue_valid;
	alu_op_t  issue_op;
	lc3b_word issue_vj;
	rs_tag_t  issue_qj;
	lc3b_word issue_vk;
	rs_tag_t  issue_qk;
	lc3b_reg  issue_dest;
	logic     issue_ready;
	logic     ext_wb_valid;
	rs_tag_t  ext_wb_tag;
	lc3b_word ext_wb_data;
	lc3b_reg  ext_wb_dest;
	logic     cdb_valid;
	rs_tag_t  cdb_tag;
	lc3b_word cdb_data;
	lc3b_reg  cdb_dest;

	// Reference model of both stations, indexed by tag minus one.
	logic     m_busy [2];
	logic     m_exp [2];
	alu_op_t  m_op [2];
	lc3b_word m_vj [2];
	lc3b_word m_vk [2];
	rs_tag_t  m_qj [2];
	rs_tag_t  m_qk [2];
	lc3b_reg  m_dest [2];
	lc3b_word m_data [2];
	int       m_iss_cyc [2];
	int       bc_count [2];
	int       bc_cycle [2];
	int       last_lat [2];
	int       last_winner;
	rs_tag_t  last_issue_tag;
	logic     ext_prev_valid;
	rs_tag_t  ext_prev_tag;
	lc3b_word ext_prev_data;
	lc3b_reg  ext_prev_dest;
	int       cycle;
	int       errors;
	int       tests_run;
	int       tests_failed;
	logic [31:0] rng_state;

	alu_exec_unit dut0 (.*);

	always #50 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state;
	endfunction

	function automatic lc3b_word rand_word();
		logic [31:0] r;
		r = lcg_next();
		return r[30:15];
	endfunction

	// Expected ALU result; shifts take the low four bits of b.
	function automatic lc3b_word ref_alu(alu_op_t op, lc3b_word a, lc3b_word b);
		lc3b_word r;
		int sh;
		sh = b[3:0];
		r = a;
		case (op)
			alu_add: r = a + b;
			alu_and: r = a & b;
			alu_not: r = ~a;
			alu_sll: r = a << sh;
			alu_srl: r = a >> sh;
			alu_sra: begin
				r = a >> sh;
				for (int i = 0; i < sh; i++) begin
					r[15 - i] = a[15]; // Fill with the sign bit.
				end
			end
			default: r = a;
		endcase
		return r;
	endfunction

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("sim failed");
			$finish;
		end
	end

	always @(negedge clk) begin
		int s;
		lc3b_word bus_val;
		if (arst_n) begin
			bus_val = '0;
			if (ext_prev_valid) begin
				bus_val = ext_prev_data;
				assert (cdb_valid && cdb_tag == ext_prev_tag && cdb_data == ext_prev_data &&
					cdb_dest == ext_prev_dest) else begin
					$display("MISMATCH at %0t: writeback tag %0d not forwarded unchanged",
						$time, ext_prev_tag);
					errors++;
				end
			end else if (cdb_valid) begin
				s = int'(cdb_tag) - 1;
				if (cdb_tag == RS0_TAG || cdb_tag == RS1_TAG) begin
					bc_count[s]++; // Expected or not.
					bc_cycle[s] = cycle;
				end
				if ((cdb_tag == RS0_TAG || cdb_tag == RS1_TAG) && m_busy[s] && m_exp[s]) begin
					bus_val = m_data[s];
					assert (cdb_data == m_data[s] && cdb_dest == m_dest[s]) else begin
						$display("MISMATCH at %0t: tag %0d data %h dest %0d, expected %h %0d",
							$time, cdb_tag, cdb_data, cdb_dest, m_data[s], m_dest[s]);
						errors++;
					end
					last_lat[s] = cycle - m_iss_cyc[s];
					last_winner = s;
					m_busy[s] = 1'b0;
				end else begin
					$display("Error at %0t: broadcast of tag %0d that no entry expects",
						$time, cdb_tag);
					errors++;
				end
			end
			for (int i = 0; i < 2; i++) begin
				if (m_busy[i] && cdb_valid && m_qj[i] != TAG_NONE && m_qj[i] == cdb_tag) begin
					m_vj[i] = bus_val;
					m_qj[i] = TAG_NONE;
				end
				if (m_busy[i] && cdb_valid && m_qk[i] != TAG_NONE && m_qk[i] == cdb_tag) begin
					m_vk[i] = bus_val;
					m_qk[i] = TAG_NONE;
				end
			end
			assert (issue_ready == !(m_busy[0] && m_busy[1])) else begin
				$display("Error at %0t: issue_ready does not follow station occupancy", $time);
				errors++;
			end
			if (issue_valid && issue_ready && !flush) begin
				s = m_busy[0] ? 1 : 0; // Station 0 preferred.
				m_busy[s] = 1'b1;
				m_exp[s] = 1'b0;
				m_op[s] = issue_op;
				m_dest[s] = issue_dest;
				m_qj[s] = issue_qj;
				m_vj[s] = issue_vj;
				m_qk[s] = issue_qk;
				m_vk[s] = issue_vk;
				if (cdb_valid && issue_qj != TAG_NONE && cdb_tag == issue_qj) begin
					m_vj[s] = bus_val;
					m_qj[s] = TAG_NONE;
				end
				if (cdb_valid && issue_qk != TAG_NONE && cdb_tag == issue_qk) begin
					m_vk[s] = bus_val;
					m_qk[s] = TAG_NONE;
				end
				m_iss_cyc[s] = cycle + 1;
				last_issue_tag = rs_tag_t'(s + 1);
			end
			for (int i = 0; i < 2; i++) begin
				if (m_busy[i] && !m_exp[i] && m_qj[i] == TAG_NONE && m_qk[i] == TAG_NONE) begin
					m_data[i] = ref_alu(m_op[i], m_vj[i], m_vk[i]);
					m_exp[i] = 1'b1;
				end
			end
			if (flush) begin
				m_busy[0] = 1'b0;
				m_busy[1] = 1'b0;
			end
			ext_prev_valid = ext_wb_valid;
			ext_prev_tag = ext_wb_tag;
			ext_prev_data = ext_wb_data;
			ext_prev_dest = ext_wb_dest;
		end
	end

	task automatic issue_one(input alu_op_t op, input lc3b_word vj, input rs_tag_t qj,
		input lc3b_word vk, input rs_tag_t qk, input lc3b_reg dest, output rs_tag_t tag);
		@(posedge clk);
		while (m_busy[0] && m_busy[1]) begin
			@(posedge clk);
		end
		issue_valid <= 1'b1;
		issue_op <= op;
		issue_vj <= vj;
		issue_qj <= qj;
		issue_vk <= vk;
		issue_qk <= qk;
		issue_dest <= dest;
		@(posedge clk);
		issue_valid <= 1'b0;
		tag = last_issue_tag;
	endtask

	task automatic send_wb(input rs_tag_t tag, input lc3b_word data, input lc3b_reg dest);
		@(posedge clk);
		ext_wb_valid <= 1'b1;
		ext_wb_tag <= tag;
		ext_wb_data <= data;
		ext_wb_dest <= dest;
		@(posedge clk);
		ext_wb_valid <= 1'b0;
	endtask

	task automatic wait_broadcast(input rs_tag_t tag, input int start);
		while (bc_count[int'(tag) - 1] == start) begin
			@(posedge clk);
		end
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: FAILED", name);
		end
	endtask

	initial begin
		rs_tag_t t0;
		rs_tag_t t1;
		int e0;
		int c0;
		int c1;
		int w0;
		clk = 1'b0;
		arst_n = 1'b0;
		flush = 1'b0;
		issue_valid = 1'b0;
		issue_op = alu_add;
		issue_vj = '0;
		issue_qj = TAG_NONE;
		issue_vk = '0;
		issue_qk = TAG_NONE;
		issue_dest = '0;
		ext_wb_valid = 1'b0;
		ext_wb_tag = 3'd3;
		ext_wb_data = '0;
		ext_wb_dest = '0;
		m_busy = '{1'b0, 1'b0};
		m_exp = '{1'b0, 1'b0};
		bc_count = '{0, 0};
		last_winner = 1;
		ext_prev_valid = 1'b0;
		cycle = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		rng_state = 32'd61;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;

		e0 = errors; // Ready operands, all six operations.
		@(negedge clk);
		assert (!cdb_valid && issue_ready) else begin
			$display("Error at %0t: unit not idle after reset", $time);
			errors++;
		end
		for (int i = 0; i < 12; i++) begin
			c0 = bc_count[0];
			issue_one(alu_op_t'(i % 6), rand_word(), TAG_NONE, rand_word(), TAG_NONE,
				lc3b_reg'(i), t0);
			wait_broadcast(t0, c0);
			assert (last_lat[0] == 3) else begin
				$display("MISMATCH at %0t: latency %0d, expected 3", $time, last_lat[0]);
				errors++;
			end
		end
		finish_test("ready_ops", e0);

		e0 = errors; // Wait on outside tags.
		c0 = bc_count[0];
		issue_one(alu_add, 16'hdead, 3'd3, 16'hbeef, 3'd4, 3'd5, t0);
		send_wb(3'd5, 16'h1111, 3'd1);
		send_wb(3'd7, 16'h2222, 3'd2);
		repeat (5) @(posedge clk);
		assert (bc_count[0] == c0) else begin
			$display("Error at %0t: station broadcast before its operands arrived", $time);
			errors++;
		end
		send_wb(3'd3, rand_word(), 3'd3);
		send_wb(3'd4, rand_word(), 3'd4);
		wait_broadcast(t0, c0);
		send_wb(3'd3, 16'h5a5a, 3'd6); // Reused tag, nobody waits on it.
		repeat (4) @(posedge clk);
		finish_test("outside_tags", e0);

		e0 = errors; // Chaining through station 0.
		c0 = bc_count[0];
		c1 = bc_count[1];
		issue_one(alu_sll, rand_word(), TAG_NONE, 16'h0003, TAG_NONE, 3'd1, t0);
		issue_one(alu_and, 16'h0ff0, RS0_TAG, rand_word(), TAG_NONE, 3'd2, t1);
		wait_broadcast(t0, c0);
		wait_broadcast(t1, c1);
		issue_one(alu_not, rand_word(), TAG_NONE, 16'h0000, TAG_NONE, 3'd3, t0);
		repeat (2) @(posedge clk);
		c1 = bc_count[0];
		issue_one(alu_add, 16'h0000, RS0_TAG, 16'h0101, TAG_NONE, 3'd4, t1); // Forwarded.
		wait_broadcast(t1, c1 + 1);
		finish_test("chaining", e0);

		e0 = errors; // Back-pressure and round robin.
		c0 = bc_count[0];
		c1 = bc_count[1];
		@(posedge clk);
		ext_wb_valid <= 1'b1;
		ext_wb_tag <= 3'd6;
		ext_wb_data <= rand_word();
		ext_wb_dest <= 3'd7;
		issue_one(alu_srl, rand_word(), TAG_NONE, rand_word(), TAG_NONE, 3'd1, t0);
		issue_one(alu_sra, 16'h8421, TAG_NONE, rand_word(), TAG_NONE, 3'd2, t1);
		repeat (5) @(posedge clk);
		assert (!issue_ready && bc_count[0] == c0 && bc_count[1] == c1) else begin
			$display("Error at %0t: station result or issue slot during back-pressure", $time);
			errors++;
		end
		ext_wb_valid <= 1'b0;
		w0 = 1 - last_winner; // The station not served last goes first.
		wait_broadcast(RS0_TAG, c0);
		wait_broadcast(RS1_TAG, c1);
		assert (bc_cycle[1 - w0] - bc_cycle[w0] == 1) else begin
			$display("Error at %0t: two ready stations did not alternate on the bus", $time);
			errors++;
		end
		finish_test("back_pressure", e0);

		e0 = errors; // Flush.
		c0 = bc_count[0];
		c1 = bc_count[1];
		issue_one(alu_add, 16'h0000, 3'd6, 16'h0001, TAG_NONE, 3'd1, t0);
		issue_one(alu_and, 16'hffff, TAG_NONE, 16'h0000, 3'd7, 3'd2, t1);
		@(posedge clk);
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
		@(negedge clk);
		assert (issue_ready) else begin
			$display("Error at %0t: issue_ready low after flush", $time);
			errors++;
		end
		send_wb(3'd6, rand_word(), 3'd3);
		send_wb(3'd7, rand_word(), 3'd4);
		repeat (6) @(posedge clk);
		assert (bc_count[0] == c0 && bc_count[1] == c1) else begin
			$display("Error at %0t: flushed entry was broadcast", $time);
			errors++;
		end
		finish_test("flush", e0);

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule : alu_exec_unit_tb

`default_nettype wire

//--- alu_exec_unit.f
verilog/lc3b_types.sv
verilog/rs_types.sv
verilog/lc3b_alu.sv
verilog/alu_res_station.sv
verilog/rs_scheduler.sv
verilog/alu_exec_unit.sv
test/alu_exec_unit_tb.sv
